/* rtl/coreTypes.sv */
package coreTypes;

    // One data or address word
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] regAddr_t;

    localparam int RegCount = 32;

    // Base opcodes, instr[6:0]
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpReg    = 7'b0110011;

    // ALU funct3 codes
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Sll    = 3'b001;
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Sltu   = 3'b011;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3Srl    = 3'b101;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    // Branch funct3 codes
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    // How the execute unit interprets funct3/funct7
    typedef enum logic [2:0] {
        AluAdd,
        AluReg,
        AluImm,
        AluBranch,
        AluLui
    } aluClass_t;

    typedef enum logic [1:0] {
        BrNone,
        BrCond,
        BrJal,
        BrJalr
    } branch_t;

endpackage

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import coreTypes::*; (
    input  word_t       instr,
    output regAddr_t    rs1Addr,
    output regAddr_t    rs2Addr,
    output regAddr_t    rdAddr,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output word_t       imm,
    output aluClass_t   aluClass,
    output logic        aluSrc,
    output logic        pcToRegSrc,
    output logic        rdSrc,
    output logic        memToReg,
    output logic        memWrite,
    output logic        memRead,
    output logic        regWrite,
    output branch_t     branch
);

    logic [6:0] opcode;
    word_t immI;
    word_t immS;
    word_t immB;
    word_t immU;
    word_t immJ;

    assign opcode  = instr[6:0];
    assign rdAddr  = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign funct7  = instr[31:25];

    // Immediate formats, all sign-extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Unknown opcode falls through with everything inactive
        imm        = '0;
        aluClass   = AluAdd;
        aluSrc     = 1'b0;
        pcToRegSrc = 1'b0;
        rdSrc      = 1'b0;
        memToReg   = 1'b0;
        memWrite   = 1'b0;
        memRead    = 1'b0;
        regWrite   = 1'b0;
        branch     = BrNone;
        case (opcode)
            OpLui: begin
                imm      = immU;
                aluClass = AluLui;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            OpAuipc: begin
                imm        = immU;
                rdSrc      = 1'b1;
                pcToRegSrc = 1'b1;
                regWrite   = 1'b1;
            end
            OpJal: begin
                imm      = immJ;
                aluSrc   = 1'b1;
                rdSrc    = 1'b1;
                regWrite = 1'b1;
                branch   = BrJal;
            end
            OpJalr: begin
                imm      = immI;
                aluSrc   = 1'b1;
                rdSrc    = 1'b1;
                regWrite = 1'b1;
                branch   = BrJalr;
            end
            OpBranch: begin
                imm      = immB;
                aluClass = AluBranch;
                branch   = BrCond;
            end
            OpLoad: begin
                imm      = immI;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            OpStore: begin
                imm      = immS;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            OpImm: begin
                imm      = immI;
                aluClass = AluImm;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            OpReg: begin
                aluClass = AluReg;
                regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    // Stores never write rd
    always_comb begin
        assert (!(regWrite && memWrite))
            else $error("regWrite and memWrite both high for opcode %b", opcode);
    end

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ps

module registerFile import coreTypes::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    output word_t    rs1Data,
    output word_t    rs2Data,
    input  logic     wbEn,
    input  regAddr_t wbAddr,
    input  word_t    wbData
);

    word_t regs [RegCount];

    // No bypass, a same-edge write is seen only by the next capture
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;
        end
    end

    // x0 always reads as zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

/* rtl/idExeReg.sv */
`timescale 1ns/1ps

module idExeReg import coreTypes::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  word_t       pc,
    input  word_t       rs1Data,
    input  word_t       rs2Data,
    input  regAddr_t    rdAddr,
    input  logic [2:0]  funct3,
    input  logic [6:0]  funct7,
    input  regAddr_t    rs1Addr,
    input  regAddr_t    rs2Addr,
    input  word_t       imm,
    input  aluClass_t   aluClass,
    input  logic        aluSrc,
    input  logic        pcToRegSrc,
    input  logic        rdSrc,
    input  logic        memToReg,
    input  logic        memWrite,
    input  logic        memRead,
    input  logic        regWrite,
    input  branch_t     branch,
    output word_t       exePc,
    output word_t       exeRs1Data,
    output word_t       exeRs2Data,
    output regAddr_t    exeRdAddr,
    output logic [2:0]  exeFunct3,
    output logic [6:0]  exeFunct7,
    output regAddr_t    exeRs1Addr,
    output regAddr_t    exeRs2Addr,
    output word_t       exeImm,
    output aluClass_t   exeAluClass,
    output logic        exeAluSrc,
    output logic        exePcToRegSrc,
    output logic        exeRdSrc,
    output logic        exeMemToReg,
    output logic        exeMemWrite,
    output logic        exeMemRead,
    output logic        exeRegWrite,
    output branch_t     exeBranch
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exePc         <= '0;
            exeRs1Data    <= '0;
            exeRs2Data    <= '0;
            exeRdAddr     <= '0;
            exeFunct3     <= '0;
            exeFunct7     <= '0;
            exeRs1Addr    <= '0;
            exeRs2Addr    <= '0;
            exeImm        <= '0;
            exeAluClass   <= AluAdd;
            exeAluSrc     <= 1'b0;
            exePcToRegSrc <= 1'b0;
            exeRdSrc      <= 1'b0;
            exeMemToReg   <= 1'b0;
            exeMemWrite   <= 1'b0;
            exeMemRead    <= 1'b0;
            exeRegWrite   <= 1'b0;
            exeBranch     <= BrNone;
        end else if (flush) begin
            // Squash side effects only, the data fields hold
            exeMemWrite <= 1'b0;
            exeMemRead  <= 1'b0;
            exeRegWrite <= 1'b0;
            exeBranch   <= BrNone;
        end else begin
            exePc         <= pc;
            exeRs1Data    <= rs1Data;
            exeRs2Data    <= rs2Data;
            exeRdAddr     <= rdAddr;
            exeFunct3     <= funct3;
            exeFunct7     <= funct7;
            exeRs1Addr    <= rs1Addr;
            exeRs2Addr    <= rs2Addr;
            exeImm        <= imm;
            exeAluClass   <= aluClass;
            exeAluSrc     <= aluSrc;
            exePcToRegSrc <= pcToRegSrc;
            exeRdSrc      <= rdSrc;
            exeMemToReg   <= memToReg;
            exeMemWrite   <= memWrite;
            exeMemRead    <= memRead;
            exeRegWrite   <= regWrite;
            exeBranch     <= branch;
        end
    end

    // A flushed slot never reaches memory or the register file
    flushSquashes: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> (!exeRegWrite && !exeMemWrite && !exeMemRead)
    ) else $error("side-effect control survived a flush");

endmodule

/* rtl/execUnit.sv */
`timescale 1ns/1ps

module execUnit import coreTypes::*; (
    input  word_t       exePc,
    input  word_t       exeRs1Data,
    input  word_t       exeRs2Data,
    input  word_t       exeImm,
    input  logic [2:0]  exeFunct3,
    input  logic [6:0]  exeFunct7,
    input  aluClass_t   exeAluClass,
    input  logic        exeAluSrc,
    input  logic        exePcToRegSrc,
    input  logic        exeRdSrc,
    input  branch_t     exeBranch,
    output word_t       exeResult,
    output logic        branchTaken,
    output word_t       branchTarget,
    output word_t       exeStoreData
);

    word_t opA;
    word_t opB;
    word_t aluResult;
    word_t pcPlusImm;
    word_t pcPlus4;
    word_t jalrTarget;
    logic [4:0] shamt;
    logic altOp;
    logic condHolds;

    assign opA   = exeRs1Data;
    assign opB   = exeAluSrc ? exeImm : exeRs2Data;
    assign shamt = opB[4:0];

    // funct7[5] picks sub/sra; for immediates it only matters on shifts
    assign altOp = exeFunct7[5] && ((exeAluClass == AluReg) || (exeFunct3 == F3Srl));

    always_comb begin
        case (exeAluClass)
            AluReg, AluImm: begin
                case (exeFunct3)
                    F3AddSub: aluResult = altOp ? (opA - opB) : (opA + opB);
                    F3Sll:    aluResult = opA << shamt;
                    F3Slt:    aluResult = {31'b0, $signed(opA) < $signed(opB)};
                    F3Sltu:   aluResult = {31'b0, opA < opB};
                    F3Xor:    aluResult = opA ^ opB;
                    F3Srl:    aluResult = altOp ? word_t'($signed(opA) >>> shamt)
                                                : (opA >> shamt);
                    F3Or:     aluResult = opA | opB;
                    default:  aluResult = opA & opB;
                endcase
            end
            AluBranch: aluResult = opA - opB;
            AluLui:    aluResult = exeImm;
            default:   aluResult = opA + opB;
        endcase
    end

    // Branch compare always on rs1 vs rs2
    always_comb begin
        case (exeFunct3)
            F3Beq:   condHolds = (exeRs1Data == exeRs2Data);
            F3Bne:   condHolds = (exeRs1Data != exeRs2Data);
            F3Blt:   condHolds = ($signed(exeRs1Data) < $signed(exeRs2Data));
            F3Bge:   condHolds = ($signed(exeRs1Data) >= $signed(exeRs2Data));
            F3Bltu:  condHolds = (exeRs1Data < exeRs2Data);
            F3Bgeu:  condHolds = (exeRs1Data >= exeRs2Data);
            default: condHolds = 1'b0;
        endcase
    end

    assign pcPlusImm  = exePc + exeImm;
    assign pcPlus4    = exePc + 32'd4;
    assign jalrTarget = (exeRs1Data + exeImm) & ~32'd1;

    assign branchTaken = (exeBranch == BrJal) || (exeBranch == BrJalr)
                      || ((exeBranch == BrCond) && condHolds);
    assign branchTarget = (exeBranch == BrJalr) ? jalrTarget : pcPlusImm;

    // Link value for JAL/JALR, pc-relative value for AUIPC
    assign exeResult = exeRdSrc ? (exePcToRegSrc ? pcPlusImm : pcPlus4) : aluResult;

    assign exeStoreData = exeRs2Data;

endmodule

/* rtl/decodeExecute.sv */
`timescale 1ns/1ps

module decodeExecute import coreTypes::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    instr,
    input  word_t    pc,
    input  logic     flush,
    input  logic     wbEn,
    input  regAddr_t wbAddr,
    input  word_t    wbData,
    output logic     exeRegWrite,
    output regAddr_t exeWriteAddr,
    output word_t    exeResult,
    output logic     exeMemRead,
    output logic     exeMemWrite,
    output word_t    exeStoreData,
    output logic     branchTaken,
    output word_t    branchTarget
);

    // Decode side
    regAddr_t rs1Addr;
    regAddr_t rs2Addr;
    regAddr_t rdAddr;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm;
    aluClass_t aluClass;
    logic aluSrc;
    logic pcToRegSrc;
    logic rdSrc;
    logic memToReg;
    logic memWrite;
    logic memRead;
    logic regWrite;
    branch_t branch;
    word_t rs1Data;
    word_t rs2Data;

    // Execute side
    word_t exePc;
    word_t exeRs1Data;
    word_t exeRs2Data;
    logic [2:0] exeFunct3;
    logic [6:0] exeFunct7;
    word_t exeImm;
    aluClass_t exeAluClass;
    logic exeAluSrc;
    logic exePcToRegSrc;
    logic exeRdSrc;
    branch_t exeBranch;

    instrDecoder decoder0 (
        .instr      (instr),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rdAddr     (rdAddr),
        .funct3     (funct3),
        .funct7     (funct7),
        .imm        (imm),
        .aluClass   (aluClass),
        .aluSrc     (aluSrc),
        .pcToRegSrc (pcToRegSrc),
        .rdSrc      (rdSrc),
        .memToReg   (memToReg),
        .memWrite   (memWrite),
        .memRead    (memRead),
        .regWrite   (regWrite),
        .branch     (branch)
    );

    registerFile regFile0 (
        .clk     (clk),
        .reset   (reset),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData)
    );

    // MEM-stage and forwarding fields have no consumer here
    idExeReg idExe0 (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .pc            (pc),
        .rs1Data       (rs1Data),
        .rs2Data       (rs2Data),
        .rdAddr        (rdAddr),
        .funct3        (funct3),
        .funct7        (funct7),
        .rs1Addr       (rs1Addr),
        .rs2Addr       (rs2Addr),
        .imm           (imm),
        .aluClass      (aluClass),
        .aluSrc        (aluSrc),
        .pcToRegSrc    (pcToRegSrc),
        .rdSrc         (rdSrc),
        .memToReg      (memToReg),
        .memWrite      (memWrite),
        .memRead       (memRead),
        .regWrite      (regWrite),
        .branch        (branch),
        .exePc         (exePc),
        .exeRs1Data    (exeRs1Data),
        .exeRs2Data    (exeRs2Data),
        .exeRdAddr     (exeWriteAddr),
        .exeFunct3     (exeFunct3),
        .exeFunct7     (exeFunct7),
        .exeRs1Addr    (),
        .exeRs2Addr    (),
        .exeImm        (exeImm),
        .exeAluClass   (exeAluClass),
        .exeAluSrc     (exeAluSrc),
        .exePcToRegSrc (exePcToRegSrc),
        .exeRdSrc      (exeRdSrc),
        .exeMemToReg   (),
        .exeMemWrite   (exeMemWrite),
        .exeMemRead    (exeMemRead),
        .exeRegWrite   (exeRegWrite),
        .exeBranch     (exeBranch)
    );

    execUnit exec0 (
        .exePc         (exePc),
        .exeRs1Data    (exeRs1Data),
        .exeRs2Data    (exeRs2Data),
        .exeImm        (exeImm),
        .exeFunct3     (exeFunct3),
        .exeFunct7     (exeFunct7),
        .exeAluClass   (exeAluClass),
        .exeAluSrc     (exeAluSrc),
        .exePcToRegSrc (exePcToRegSrc),
        .exeRdSrc      (exeRdSrc),
        .exeBranch     (exeBranch),
        .exeResult     (exeResult),
        .branchTaken   (branchTaken),
        .branchTarget  (branchTarget),
        .exeStoreData  (exeStoreData)
    );

endmodule

/* verif/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    localparam int HalfPeriodNs = 20;
    localparam int ResetCycles  = 10;

    initial begin
        clk = 1'b0;
        forever #HalfPeriodNs clk = ~clk;
    end

    // Release on a falling edge, away from the capture edge
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* verif/exeChecker.sv */
`timescale 1ns/1ps

module exeChecker import coreTypes::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    instr,
    input  word_t    pc,
    input  logic     flush,
    input  logic     wbEn,
    input  regAddr_t wbAddr,
    input  word_t    wbData,
    input  logic     exeRegWrite,
    input  regAddr_t exeWriteAddr,
    input  word_t    exeResult,
    input  logic     exeMemRead,
    input  logic     exeMemWrite,
    input  word_t    exeStoreData,
    input  logic     branchTaken,
    input  word_t    branchTarget,
    output int       errorCount,
    output int       checkCount
);

    word_t modelRegs [32];
    int errors = 0;
    int checks = 0;
    logic armed = 1'b0;

    // Expected outputs of the instruction now in execute
    word_t expInstr;
    logic expRegWrite;
    logic expMemRead;
    logic expMemWrite;
    logic expTaken;
    word_t expResult;
    word_t expTarget;
    word_t expStore;
    regAddr_t expRd;
    logic checkResult;
    logic checkTarget;

    // Data fields that a flushed slot keeps
    word_t heldResult;
    word_t heldStore;
    regAddr_t heldRd;
    logic heldResultValid;

    assign errorCount = errors;
    assign checkCount = checks;

    function automatic word_t readReg(input regAddr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end
        return modelRegs[addr];
    endfunction

    function automatic word_t aluOp(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? (a - b) : (a + b);
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic condHolds(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic clearControls();
        expRegWrite = 1'b0;
        expMemRead  = 1'b0;
        expMemWrite = 1'b0;
        expTaken    = 1'b0;
        checkTarget = 1'b0;
    endtask

    task automatic predict(input word_t ins, input word_t pcVal);
        logic [2:0] f3;
        word_t rs1v;
        word_t rs2v;
        word_t immI;
        word_t immS;
        word_t immB;
        word_t immU;
        word_t immJ;
        f3   = ins[14:12];
        rs1v = readReg(ins[19:15]);
        rs2v = readReg(ins[24:20]);
        immI = word_t'($signed(ins[31:20]));
        immS = word_t'($signed({ins[31:25], ins[11:7]}));
        immB = word_t'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        immU = {ins[31:12], 12'h000};
        immJ = word_t'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        clearControls();
        expInstr    = ins;
        expRd       = ins[11:7];
        expStore    = rs2v;
        expResult   = '0;
        expTarget   = '0;
        checkResult = 1'b1;
        case (ins[6:0])
            OpReg: begin
                expRegWrite = 1'b1;
                expResult   = aluOp(f3, ins[30], rs1v, rs2v);
            end
            OpImm: begin
                // Only srai uses the upper immediate bits
                expRegWrite = 1'b1;
                expResult   = aluOp(f3, (f3 == 3'b101) && ins[30], rs1v, immI);
            end
            OpLoad: begin
                expRegWrite = 1'b1;
                expMemRead  = 1'b1;
                expResult   = rs1v + immI;
            end
            OpStore: begin
                expMemWrite = 1'b1;
                expResult   = rs1v + immS;
            end
            OpBranch: begin
                checkResult = 1'b0;
                checkTarget = 1'b1;
                expTaken    = condHolds(f3, rs1v, rs2v);
                expTarget   = pcVal + immB;
            end
            OpJal: begin
                expRegWrite = 1'b1;
                expTaken    = 1'b1;
                checkTarget = 1'b1;
                expTarget   = pcVal + immJ;
                expResult   = pcVal + 32'd4;
            end
            OpJalr: begin
                expRegWrite = 1'b1;
                expTaken    = 1'b1;
                checkTarget = 1'b1;
                expTarget   = (rs1v + immI) & 32'hffff_fffe;
                expResult   = pcVal + 32'd4;
            end
            OpLui: begin
                expRegWrite = 1'b1;
                expResult   = immU;
            end
            OpAuipc: begin
                expRegWrite = 1'b1;
                expResult   = pcVal + immU;
            end
            default: checkResult = 1'b0;
        endcase
    endtask

    task automatic compareWord(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h (instr %h)",
                     $time, name, got, expected, expInstr);
        end
    endtask

    // Model state moves at the capture edge; reads see only earlier writes
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                modelRegs[i] = '0;
            end
            clearControls();
            expInstr        = '0;
            expResult       = '0;
            expTarget       = '0;
            expStore        = '0;
            expRd           = '0;
            checkResult     = 1'b0;
            heldResult      = '0;
            heldStore       = '0;
            heldRd          = '0;
            heldResultValid = 1'b0;
        end else begin
            if (flush) begin
                clearControls();
                expResult   = heldResult;
                checkResult = heldResultValid;
                expStore    = heldStore;
                expRd       = heldRd;
            end else begin
                predict(instr, pc);
                heldResult      = expResult;
                heldResultValid = checkResult;
                heldStore       = expStore;
                heldRd          = expRd;
            end
            if (wbEn && (wbAddr != 5'd0)) begin
                modelRegs[wbAddr] = wbData;
            end
        end
        armed = 1'b1;
    end

    // Execute outputs are stable at the falling edge
    always @(negedge clk) begin
        if (armed) begin
            compareWord("exeRegWrite", word_t'(exeRegWrite), word_t'(expRegWrite));
            compareWord("exeMemRead", word_t'(exeMemRead), word_t'(expMemRead));
            compareWord("exeMemWrite", word_t'(exeMemWrite), word_t'(expMemWrite));
            compareWord("branchTaken", word_t'(branchTaken), word_t'(expTaken));
            compareWord("exeWriteAddr", word_t'(exeWriteAddr), word_t'(expRd));
            compareWord("exeStoreData", exeStoreData, expStore);
            if (checkResult) begin
                compareWord("exeResult", exeResult, expResult);
            end
            if (checkTarget) begin
                compareWord("branchTarget", branchTarget, expTarget);
            end
        end
    end

endmodule

/* verif/tbDecodeExecute.sv */
`timescale 1ns/1ps

module tbDecodeExecute import coreTypes::*; ();

    localparam logic [31:0] Seed = 32'h55d9_3f38;
    // Feedback taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LfsrTaps = 32'h8020_0003;
    localparam int TrafficCycles = 3000;
    localparam int ResetTimeout  = 50;
    localparam int WatchdogNs    = (TrafficCycles + 200) * 40;

    logic clk;
    logic reset;
    word_t instr;
    word_t pc;
    logic flush;
    logic wbEn;
    regAddr_t wbAddr;
    word_t wbData;
    logic exeRegWrite;
    regAddr_t exeWriteAddr;
    word_t exeResult;
    logic exeMemRead;
    logic exeMemWrite;
    word_t exeStoreData;
    logic branchTaken;
    word_t branchTarget;
    int errorCount;
    int checkCount;
    logic [31:0] lfsrState;
    int waitCount;

    clockGen clockGen0 (
        .clk   (clk),
        .reset (reset)
    );

    decodeExecute dut0 (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .pc           (pc),
        .flush        (flush),
        .wbEn         (wbEn),
        .wbAddr       (wbAddr),
        .wbData       (wbData),
        .exeRegWrite  (exeRegWrite),
        .exeWriteAddr (exeWriteAddr),
        .exeResult    (exeResult),
        .exeMemRead   (exeMemRead),
        .exeMemWrite  (exeMemWrite),
        .exeStoreData (exeStoreData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    exeChecker checker0 (.*);

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return value;
    endfunction

    function automatic word_t makeInstr();
        logic [3:0] kind;
        regAddr_t rd;
        regAddr_t rs1;
        regAddr_t rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm12;
        logic [19:0] upper;
        kind  = 4'(randBits(4));
        rd    = regAddr_t'(randBits(5));
        rs1   = regAddr_t'(randBits(5));
        rs2   = regAddr_t'(randBits(5));
        f3    = 3'(randBits(3));
        imm12 = 12'(randBits(12));
        upper = 20'(randBits(20));
        case (kind)
            4'd0, 4'd1, 4'd2: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && randBits(1) == 32'd1) ? 7'h20 : 7'h00;
                return {f7, rs2, rs1, f3, rd, OpReg};
            end
            4'd3, 4'd4, 4'd5: begin
                if (f3 == 3'b001) begin
                    imm12[11:5] = 7'h00;
                end
                if (f3 == 3'b101) begin
                    imm12[11:5] = (randBits(1) == 32'd1) ? 7'h20 : 7'h00;
                end
                return {imm12, rs1, f3, rd, OpImm};
            end
            4'd6:  return {imm12, rs1, 3'b010, rd, OpLoad};
            4'd7:  return {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OpStore};
            4'd8, 4'd9, 4'd10: begin
                // Remap the two unused funct3 codes, and often compare a register with itself
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    f3 = f3 ^ 3'b100;
                end
                if (randBits(2) == 32'd0) begin
                    rs2 = rs1;
                end
                return {imm12[11:5], rs2, rs1, f3, imm12[4:0], OpBranch};
            end
            4'd11: return {upper, rd, OpJal};
            4'd12: return {imm12, rs1, 3'b000, rd, OpJalr};
            4'd13: return {upper, rd, OpLui};
            4'd14: return {upper, rd, OpAuipc};
            default: return {upper, rd, 7'b0001011};
        endcase
    endfunction

    task automatic driveIdle();
        instr  = '0;
        pc     = '0;
        flush  = 1'b0;
        wbEn   = 1'b0;
        wbAddr = '0;
        wbData = '0;
    endtask

    // x0 is written too, and must stay zero
    task automatic writeAllRegisters();
        for (int i = 0; i < 32; i++) begin
            wbEn   = 1'b1;
            wbAddr = regAddr_t'(i);
            wbData = randBits(32);
            @(negedge clk);
        end
    endtask

    task automatic runTraffic();
        for (int n = 0; n < TrafficCycles; n++) begin
            instr  = makeInstr();
            pc     = randBits(30) << 2;
            flush  = (randBits(3) == 32'd0);
            wbEn   = (randBits(1) == 32'd1);
            wbAddr = (randBits(2) == 32'd0) ? instr[19:15] : regAddr_t'(randBits(5));
            wbData = randBits(32);
            @(negedge clk);
        end
    endtask

    task automatic drainPipeline();
        driveIdle();
        @(negedge clk);
        @(negedge clk);
    endtask

    initial begin
        driveIdle();
        lfsrState = Seed;
        waitCount = 0;
        while (reset !== 1'b0 && waitCount < ResetTimeout) begin
            @(negedge clk);
            waitCount++;
        end
        if (reset !== 1'b0) begin
            $display("Timeout: reset still high after %0d cycles", ResetTimeout);
            $display("STATUS: FAIL");
        end else begin
            writeAllRegisters();
            runTraffic();
            drainPipeline();
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            if (errorCount == 0 && checkCount > 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
        end
        $finish;
    end

    initial begin
        #WatchdogNs;
        $display("Timeout: simulation did not finish within %0d ns", WatchdogNs);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* sim.f */
rtl/coreTypes.sv
rtl/instrDecoder.sv
rtl/registerFile.sv
rtl/idExeReg.sv
rtl/execUnit.sv
rtl/decodeExecute.sv
verif/clockGen.sv
verif/exeChecker.sv
verif/tbDecodeExecute.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tbDecodeExecute
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= -Wall
FAIL_MSG   ?= STATUS: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
